/* vlog.f */
design/video_pkg.sv
design/color_pkg.sv
design/video_capture.sv
design/channel_conv.sv
design/line_ram_writer.sv
design/capture_top.sv
bench/tb_capture.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_capture -f vlog.f -o tb_capture \
    && ./obj_dir/tb_capture > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "TEST PASSED" sim.log && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

/* bench/tb_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_capture;

    import video_pkg::*;
    import color_pkg::*;

    localparam int COLUMNS = 64;
    localparam int LINES = 40;
    localparam int RASTER_CYCLES = COLUMNS * LINES;
    localparam int NUM_FRAMES = 8;
    // Reading back a frame never takes more cycles than the frame itself.
    localparam int CYCLE_LIMIT = NUM_FRAMES * 2 * RASTER_CYCLES + 200;

    logic      clock;
    logic      nreset;
    coord_t    counter_x;
    coord_t    counter_y;
    channel_t  red;
    channel_t  green;
    channel_t  blue;
    coord_t    h_start;
    coord_t    h_end;
    coord_t    v_start;
    coord_t    v_end;
    ram_addr_t line_length;
    ram_addr_t ram_words;
    ram_addr_t trigger_addr;
    coord_t    buffer_lines;
    logic [7:0] color_config;
    ram_addr_t rd_addr;
    logic      write_strobe;
    logic      start_trigger;
    pixel_t    rd_data;

    // Frame configuration as the model sees it.
    coord_t    cfg_h_start;
    coord_t    cfg_h_end;
    coord_t    cfg_v_start;
    coord_t    cfg_v_end;
    ram_addr_t cfg_line_length;
    ram_addr_t cfg_ram_words;
    ram_addr_t cfg_trigger_addr;
    coord_t    cfg_buffer_lines;
    logic [7:0] cfg_color;

    logic [31:0] rng_state;
    pixel_t    shadow [RAM_DEPTH];
    logic      written [RAM_DEPTH];
    ram_addr_t model_base;
    logic [2:0] strobe_pipe;
    logic [2:0] trig_pipe;
    logic      read_pending;
    ram_addr_t read_addr_d;
    pixel_t    read_expected;
    int        error_count;
    int        read_checks;
    int        trigger_count;
    int        cycle_count = 0;
    logic      finished;

    capture_top i_dut (
        .clock         (clock),
        .nreset        (nreset),
        .counter_x     (counter_x),
        .counter_y     (counter_y),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .h_start       (h_start),
        .h_end         (h_end),
        .v_start       (v_start),
        .v_end         (v_end),
        .line_length   (line_length),
        .ram_words     (ram_words),
        .trigger_addr  (trigger_addr),
        .buffer_lines  (buffer_lines),
        .color_config  (color_config),
        .rd_addr       (rd_addr),
        .write_strobe  (write_strobe),
        .start_trigger (start_trigger),
        .rd_data       (rd_data)
    );

    initial begin
        clock = 1'b0;
    end

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT && !finished) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // 0 passes, 1 inverts, 2 halves, 3 blanks the sample.
    function automatic channel_t convert_sample(input channel_t sample, input logic [1:0] mode);
        case (mode)
            2'd0: return sample;
            2'd1: return ~sample;
            2'd2: return sample >> 1;
            default: return '0;
        endcase
    endfunction

    // Channel i sits in byte i of the word and takes bits 2i+1 and 2i of the configuration.
    function automatic pixel_t expected_pixel(input pixel_t raw, input logic [7:0] cfg);
        pixel_t result;
        result = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            result[CHANNEL_WIDTH*i +: CHANNEL_WIDTH] =
                convert_sample(raw[CHANNEL_WIDTH*i +: CHANNEL_WIDTH], cfg[2*i +: 2]);
        end
        return result;
    endfunction

    task automatic init_inputs();
        nreset <= 1'b0;
        counter_x <= coord_t'(COLUMNS - 1);
        counter_y <= coord_t'(LINES - 1);
        red <= '0;
        green <= '0;
        blue <= '0;
        h_start <= '0;
        h_end <= '0;
        v_start <= '0;
        v_end <= '0;
        line_length <= '0;
        ram_words <= '0;
        trigger_addr <= '0;
        buffer_lines <= '0;
        color_config <= '0;
        rd_addr <= '0;
    endtask

    // Odd frames get a buffer of only a few lines, so the base wraps.
    task automatic configure_frame(input int frame);
        int width;
        int height;
        int lines_fit;
        logic [31:0] rnd;
        cfg_h_start = coord_t'(next_random() % 16);
        width = 8 + int'(next_random() % 32);
        cfg_h_end = cfg_h_start + coord_t'(width);
        cfg_v_start = coord_t'(1 + next_random() % 8);
        height = 4 + int'(next_random() % 20);
        cfg_v_end = cfg_v_start + coord_t'(height);
        cfg_line_length = ram_addr_t'(width + int'(next_random() % 8));
        if (frame % 2 == 1) begin
            lines_fit = 2 + int'(next_random() % 3);
        end else begin
            lines_fit = height + 1 + int'(next_random() % 8);
        end
        cfg_ram_words = ram_addr_t'(lines_fit * int'(cfg_line_length));
        cfg_buffer_lines = coord_t'(next_random() % (height + 1));
        rnd = next_random();
        cfg_trigger_addr = ram_addr_t'(int'(rnd % lines_fit) * int'(cfg_line_length)
                                       + int'(next_random() % width));
        rnd = next_random();
        cfg_color = rnd[7:0];
        for (int a = 0; a < RAM_DEPTH; a++) begin
            written[ram_addr_t'(a)] = 1'b0;
        end
    endtask

    task automatic step_cycle(input coord_t x, input coord_t y, input ram_addr_t raddr,
                              input logic do_read);
        logic [31:0] rnd;
        pixel_t      raw;
        logic        in_win;
        logic        trig;
        ram_addr_t   addr;
        coord_t      line_offset;
        rnd = next_random();
        raw = rnd[23:0];
        @(posedge clock);
        counter_x <= x;
        counter_y <= y;
        red <= raw[23:16];
        green <= raw[15:8];
        blue <= raw[7:0];
        h_start <= cfg_h_start;
        h_end <= cfg_h_end;
        v_start <= cfg_v_start;
        v_end <= cfg_v_end;
        line_length <= cfg_line_length;
        ram_words <= cfg_ram_words;
        trigger_addr <= cfg_trigger_addr;
        buffer_lines <= cfg_buffer_lines;
        color_config <= cfg_color;
        rd_addr <= raddr;

        in_win = (y >= cfg_v_start) && (y < cfg_v_end) && (x >= cfg_h_start) && (x < cfg_h_end);
        addr = model_base + ram_addr_t'(x - cfg_h_start);
        line_offset = y - cfg_v_start;
        trig = in_win && (line_offset < cfg_buffer_lines) && (addr == cfg_trigger_addr);
        if (in_win) begin
            shadow[addr] = expected_pixel(raw, cfg_color);
            written[addr] = 1'b1;
        end
        // The base moves after the pixel at the right edge has used the old one.
        if (x == cfg_h_end) begin
            if ((y >= cfg_v_start) && (y < cfg_v_end)
                    && (model_base < cfg_ram_words - cfg_line_length)) begin
                model_base = model_base + cfg_line_length;
            end else begin
                model_base = '0;
            end
        end
        strobe_pipe = {strobe_pipe[1:0], in_win};
        trig_pipe = {trig_pipe[1:0], trig};

        @(negedge clock);
        if (write_strobe !== strobe_pipe[2]) begin
            $display("FAIL %0t write_strobe expected %0b actual %0b",
                     $time, strobe_pipe[2], write_strobe);
            error_count++;
        end
        if (start_trigger !== trig_pipe[2]) begin
            $display("FAIL %0t start_trigger expected %0b actual %0b",
                     $time, trig_pipe[2], start_trigger);
            error_count++;
        end
        if (start_trigger === 1'b1) begin
            trigger_count++;
        end
        if (read_pending) begin
            read_checks++;
            if (rd_data !== read_expected) begin
                $display("FAIL %0t rd_data at address %0d expected %06h actual %06h",
                         $time, read_addr_d, read_expected, rd_data);
                error_count++;
            end
        end
        read_pending = do_read;
        read_addr_d = raddr;
        read_expected = shadow[raddr];
    endtask

    initial begin
        rng_state = 32'hd2f6_6424;
        error_count = 0;
        read_checks = 0;
        trigger_count = 0;
        finished = 1'b0;
        model_base = '0;
        strobe_pipe = '0;
        trig_pipe = '0;
        read_pending = 1'b0;
        read_addr_d = '0;
        read_expected = '0;
        cfg_h_start = '0;
        cfg_h_end = '0;
        cfg_v_start = '0;
        cfg_v_end = '0;
        cfg_line_length = '0;
        cfg_ram_words = '0;
        cfg_trigger_addr = '0;
        cfg_buffer_lines = '0;
        cfg_color = '0;
        init_inputs();
        repeat (5) @(posedge clock);
        nreset <= 1'b1;

        for (int frame = 0; frame < NUM_FRAMES; frame++) begin
            configure_frame(frame);
            for (int y = 0; y < LINES; y++) begin
                for (int x = 0; x < COLUMNS; x++) begin
                    step_cycle(coord_t'(x), coord_t'(y), '0, 1'b0);
                end
            end
            // Counters rest below the window while the buffer is read back.
            for (int a = 0; a < RAM_DEPTH; a++) begin
                if (written[ram_addr_t'(a)]) begin
                    step_cycle(coord_t'(COLUMNS - 1), coord_t'(LINES - 1),
                               ram_addr_t'(a), 1'b1);
                end
            end
        end
        step_cycle(coord_t'(COLUMNS - 1), coord_t'(LINES - 1), '0, 1'b0);

        if (read_checks == 0) begin
            $display("No pixel was captured, so nothing could be read back");
            error_count++;
        end
        if (trigger_count == 0) begin
            $display("No start_trigger pulse occurred, so the trigger rule was never exercised");
            error_count++;
        end
        finished = 1'b1;
        $display("Errors: %0d, words read back: %0d, trigger pulses: %0d",
                 error_count, read_checks, trigger_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/capture_top.sv */
`timescale 1ns/1ps
`default_nettype none

module capture_top (
    input  wire                    clock,
    input  wire                    nreset,
    input  wire video_pkg::coord_t    counter_x,
    input  wire video_pkg::coord_t    counter_y,
    input  wire color_pkg::channel_t  red,
    input  wire color_pkg::channel_t  green,
    input  wire color_pkg::channel_t  blue,
    input  wire video_pkg::coord_t    h_start,
    input  wire video_pkg::coord_t    h_end,
    input  wire video_pkg::coord_t    v_start,
    input  wire video_pkg::coord_t    v_end,
    input  wire video_pkg::ram_addr_t line_length,
    input  wire video_pkg::ram_addr_t ram_words,
    input  wire video_pkg::ram_addr_t trigger_addr,
    input  wire video_pkg::coord_t    buffer_lines,
    input  wire [7:0]              color_config,
    input  wire video_pkg::ram_addr_t rd_addr,
    output logic                   write_strobe,
    output logic                   start_trigger,
    output color_pkg::pixel_t      rd_data
);

    import video_pkg::*;
    import color_pkg::*;

    logic                    cap_valid;
    logic                    cap_trigger;
    ram_addr_t               cap_addr;
    channel_t                cap_sample [NUM_CHANNELS];
    logic [NUM_CHANNELS-1:0] conv_valid;
    pixel_t                  conv_pixel;

    // Channel 2 is red, channel 0 is blue, matching the byte order of pixel_t.
    video_capture i_capture (
        .clock        (clock),
        .nreset       (nreset),
        .counter_x    (counter_x),
        .counter_y    (counter_y),
        .h_start      (h_start),
        .h_end        (h_end),
        .v_start      (v_start),
        .v_end        (v_end),
        .line_length  (line_length),
        .ram_words    (ram_words),
        .trigger_addr (trigger_addr),
        .buffer_lines (buffer_lines),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .cap_valid    (cap_valid),
        .cap_addr     (cap_addr),
        .cap_trigger  (cap_trigger),
        .cap_red      (cap_sample[2]),
        .cap_green    (cap_sample[1]),
        .cap_blue     (cap_sample[0])
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_conv
        channel_conv i_conv (
            .clock       (clock),
            .nreset      (nreset),
            .mode        (color_mode_t'(color_config[MODE_WIDTH*i +: MODE_WIDTH])),
            .in_valid    (cap_valid),
            .in_sample   (cap_sample[i]),
            .conv_valid  (conv_valid[i]),
            .conv_sample (conv_pixel[CHANNEL_WIDTH*i +: CHANNEL_WIDTH])
        );
    end

    // All converters share one strobe, so channel 0 speaks for the word.
    line_ram_writer i_writer (
        .clock         (clock),
        .nreset        (nreset),
        .conv_valid    (conv_valid[0]),
        .conv_pixel    (conv_pixel),
        .cap_addr      (cap_addr),
        .cap_trigger   (cap_trigger),
        .rd_addr       (rd_addr),
        .write_strobe  (write_strobe),
        .start_trigger (start_trigger),
        .rd_data       (rd_data)
    );

endmodule

`default_nettype wire

/* design/line_ram_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_ram_writer (
    input  wire                      clock,
    input  wire                      nreset,
    input  wire                      conv_valid,
    input  wire color_pkg::pixel_t      conv_pixel,
    input  wire video_pkg::ram_addr_t   cap_addr,
    input  wire                      cap_trigger,
    input  wire video_pkg::ram_addr_t   rd_addr,
    output logic                     write_strobe,
    output logic                     start_trigger,
    output color_pkg::pixel_t        rd_data
);

    import video_pkg::*;
    import color_pkg::*;

    pixel_t    ram [RAM_DEPTH];
    ram_addr_t addr_d;
    logic      trig_d;

    // The converters add one stage, so the address and trigger wait one cycle too.
    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            trig_d <= 1'b0;
        end else begin
            trig_d <= cap_trigger;
        end
    end

    always_ff @(posedge clock) begin
        addr_d <= cap_addr;
    end

    always_ff @(posedge clock) begin
        if (conv_valid) begin
            ram[addr_d] <= conv_pixel;
        end
    end

    // A read of the address being written returns the old word.
    always_ff @(posedge clock) begin
        rd_data <= ram[rd_addr];
    end

    assign write_strobe = conv_valid;
    assign start_trigger = trig_d;

    // The trigger travels beside the capture strobe through both stages.
    trigger_with_write: assert property (
        @(posedge clock) disable iff (!nreset)
        start_trigger |-> write_strobe
    ) else $error("start_trigger without write_strobe");

endmodule

`default_nettype wire

/* design/channel_conv.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_conv (
    input  wire                      clock,
    input  wire                      nreset,
    input  wire color_pkg::color_mode_t mode,
    input  wire                      in_valid,
    input  wire color_pkg::channel_t    in_sample,
    output logic                     conv_valid,
    output color_pkg::channel_t      conv_sample
);

    import color_pkg::*;

    channel_t converted;

    always_comb begin
        case (mode)
            mode_pass: begin
                converted = in_sample;
            end
            mode_invert: begin
                converted = ~in_sample;
            end
            mode_half: begin
                converted = in_sample >> 1;
            end
            // mode_zero blanks the channel.
            default: begin
                converted = '0;
            end
        endcase
    end

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            conv_valid <= 1'b0;
        end else begin
            conv_valid <= in_valid;
        end
    end

    // The sample is only loaded with a strobe, so it keeps the last pixel.
    always_ff @(posedge clock) begin
        if (in_valid) begin
            conv_sample <= converted;
        end
    end

endmodule

`default_nettype wire

/* design/video_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module video_capture (
    input  wire                  clock,
    input  wire                  nreset,
    input  wire video_pkg::coord_t    counter_x,
    input  wire video_pkg::coord_t    counter_y,
    input  wire video_pkg::coord_t    h_start,
    input  wire video_pkg::coord_t    h_end,
    input  wire video_pkg::coord_t    v_start,
    input  wire video_pkg::coord_t    v_end,
    input  wire video_pkg::ram_addr_t line_length,
    input  wire video_pkg::ram_addr_t ram_words,
    input  wire video_pkg::ram_addr_t trigger_addr,
    input  wire video_pkg::coord_t    buffer_lines,
    input  wire color_pkg::channel_t  red,
    input  wire color_pkg::channel_t  green,
    input  wire color_pkg::channel_t  blue,
    output logic                 cap_valid,
    output video_pkg::ram_addr_t cap_addr,
    output logic                 cap_trigger,
    output color_pkg::channel_t  cap_red,
    output color_pkg::channel_t  cap_green,
    output color_pkg::channel_t  cap_blue
);

    import video_pkg::*;
    import color_pkg::*;

    logic      h_in;
    logic      v_in;
    logic      in_window;
    logic      at_trigger;
    coord_t    col_offset;
    coord_t    line_offset;
    ram_addr_t line_base;
    ram_addr_t wr_addr;
    pixel_t    cap_pixel;

    assign v_in = (counter_y >= v_start) && (counter_y < v_end);
    assign h_in = (counter_x >= h_start) && (counter_x < h_end);
    assign in_window = v_in && h_in;

    assign col_offset = counter_x - h_start;
    assign wr_addr = line_base + ram_addr_t'(col_offset);

    // Only meaningful inside the window, where counter_y is at least v_start.
    assign line_offset = counter_y - v_start;
    assign at_trigger = (line_offset < buffer_lines) && (wr_addr == trigger_addr);

    // The base moves once per line, when the counter reaches the right edge.
    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            line_base <= '0;
        end else if (counter_x == h_end) begin
            if (v_in && (line_base < ram_words - line_length)) begin
                line_base <= line_base + line_length;
            end else begin
                line_base <= '0;
            end
        end
    end

    always_ff @(posedge clock or negedge nreset) begin
        if (!nreset) begin
            cap_valid <= 1'b0;
            cap_trigger <= 1'b0;
        end else begin
            cap_valid <= in_window;
            cap_trigger <= in_window && at_trigger;
        end
    end

    // Address and samples hold their last captured value between pixels.
    always_ff @(posedge clock) begin
        if (in_window) begin
            cap_addr <= wr_addr;
            cap_pixel <= {red, green, blue};
        end
    end

    assign cap_red = cap_pixel[2*CHANNEL_WIDTH +: CHANNEL_WIDTH];
    assign cap_green = cap_pixel[CHANNEL_WIDTH +: CHANNEL_WIDTH];
    assign cap_blue = cap_pixel[0 +: CHANNEL_WIDTH];

    // The line base walk must keep every captured pixel inside the buffer.
    addr_in_range: assert property (
        @(posedge clock) disable iff (!nreset)
        cap_valid |-> (cap_addr < ram_words)
    ) else $error("cap_addr %0d is not below ram_words %0d", cap_addr, ram_words);

endmodule

`default_nettype wire

/* design/color_pkg.sv */
`default_nettype none

package color_pkg;

    localparam int CHANNEL_WIDTH = 8;
    localparam int NUM_CHANNELS = 3;
    localparam int MODE_WIDTH = 2;

    // Red sits in the upper byte, blue in the lower one.
    localparam int PIXEL_WIDTH = NUM_CHANNELS * CHANNEL_WIDTH;

    typedef logic [CHANNEL_WIDTH-1:0] channel_t;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // Per channel conversion, selected by a 2-bit slice of color_config.
    typedef enum logic [MODE_WIDTH-1:0] {
        mode_pass   = 2'd0,
        mode_invert = 2'd1,
        mode_half   = 2'd2,
        mode_zero   = 2'd3
    } color_mode_t;

endpackage

`default_nettype wire

/* design/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Raster counters and window limits share one width.
    localparam int COORD_WIDTH = 12;

    // Word address into the line buffer.
    localparam int RAM_ADDR_WIDTH = 12;

    // The line buffer spans the whole address range.
    localparam int RAM_DEPTH = 1 << RAM_ADDR_WIDTH;

    // Pixel counter value, used for both x and y.
    typedef logic [COORD_WIDTH-1:0] coord_t;

    // Line buffer word address.
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

endpackage

`default_nettype wire
